// ==== common/jpeg_hdr_pkg.sv ====
// Shared types and marker codes for the byte-serial JPEG header parser
// Baseline markers only; RSTn and EOI are not recognised as standalone

package jpeg_hdr_pkg;

    // ==================================================
    // Stream and field widths
    // ==================================================
    typedef logic [7:0]  byte_t;       // One stream byte
    typedef logic [15:0] word_t;       // Length, dimension or coefficient
    typedef logic [1:0]  qt_id_t;      // Quantization table id
    typedef logic [5:0]  coeff_idx_t;  // Coefficient slot 0..63

    // ==================================================
    // Parser states
    // ==================================================
    typedef enum logic [2:0] {
        find_ff,  // Hunting for a marker prefix
        got_ff,   // Prefix seen, next byte is the code
        len_hi,   // Segment length, high byte
        len_lo,   // Segment length, low byte
        sof,      // SOF0 payload
        dqt,      // DQT payload
        skip,     // Any other payload, SOS header too
        pass      // Entropy-coded data forwarded until reset
    } parser_state_t;

    // Marker codes
    localparam byte_t MARK_PREFIX = 8'hFF;
    localparam byte_t MARK_SOI    = 8'hD8; // No length field follows
    localparam byte_t MARK_SOF0   = 8'hC0;
    localparam byte_t MARK_DQT    = 8'hDB;
    localparam byte_t MARK_SOS    = 8'hDA;

endpackage

// ==== dqt/dqt_loader.sv ====
// DQT payload decoder with QT_COUNT x 64 coefficient memory and read port
// Tables with ids at or above QT_COUNT are parsed but not stored

`timescale 1ns/10ps

module dqt_loader import jpeg_hdr_pkg::*; #(
    parameter int QT_COUNT = 4
) (
    input  logic       clk,
    input  logic       rst_n,
    input  byte_t      data_in,
    input  logic       data_valid,
    input  logic       dqt_en,
    input  logic       dqt_start,
    input  qt_id_t     qt_rd_id,
    input  coeff_idx_t qt_rd_idx,
    output logic       qtable_loaded,
    output qt_id_t     qtable_id,
    output word_t      qt_rd_data   // One cycle after the read address
);

    // ==================================================
    // Payload phase
    // ==================================================
    logic       in_info;     // Next byte is Pq/Tq
    logic       p16;         // 16-bit precision
    logic       wr_ok;       // Id fits in the memory
    logic       hi_pend;     // High byte of a 16-bit value is held
    qt_id_t     cur_id;
    coeff_idx_t coeff_idx;
    byte_t      hi_byte;
    logic       coeff_done;  // Current byte completes a coefficient
    word_t      coeff;

    logic       tbl_valid [QT_COUNT];  // Table loaded since reset
    word_t      qt_mem    [QT_COUNT][64];

    assign coeff_done = dqt_en && data_valid && !in_info && (!p16 || hi_pend);
    assign coeff      = p16 ? {hi_byte, data_in} : {8'h00, data_in};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_info       <= 1'b0;
            p16           <= 1'b0;
            wr_ok         <= 1'b0;
            hi_pend       <= 1'b0;
            cur_id        <= '0;
            coeff_idx     <= '0;
            qtable_loaded <= 1'b0;
            qtable_id     <= '0;
            for (int t = 0; t < QT_COUNT; t++) tbl_valid[t] <= 1'b0;
        end else begin
            qtable_loaded <= 1'b0;                     // Pulse
            if (dqt_start && data_valid) begin
                in_info <= 1'b1;
            end else if (dqt_en && data_valid) begin
                if (in_info) begin
                    p16       <= |data_in[7:4];        // Pq nonzero
                    cur_id    <= data_in[1:0];
                    wr_ok     <= int'(data_in[3:0]) < QT_COUNT;
                    coeff_idx <= '0;
                    hi_pend   <= 1'b0;
                    in_info   <= 1'b0;
                end else if (p16 && !hi_pend) begin
                    hi_pend <= 1'b1;
                end else begin
                    hi_pend   <= 1'b0;
                    coeff_idx <= coeff_idx + 6'd1;     // Wraps after 63
                    if (coeff_idx == 6'd63) begin
                        qtable_loaded <= 1'b1;
                        qtable_id     <= cur_id;
                        in_info       <= 1'b1;         // Another table may follow
                        if (wr_ok) tbl_valid[cur_id] <= 1'b1;
                    end
                end
            end
        end
    end

    // ==================================================
    // Table memory
    // ==================================================
    always_ff @(posedge clk) begin
        if (dqt_en && data_valid && !in_info && p16 && !hi_pend) hi_byte <= data_in;
        if (coeff_done && wr_ok) qt_mem[cur_id][coeff_idx] <= coeff;
    end

    // Tables not yet loaded read as zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            qt_rd_data <= '0;
        end else if (int'(qt_rd_id) < QT_COUNT && tbl_valid[qt_rd_id]) begin
            qt_rd_data <= qt_mem[qt_rd_id][qt_rd_idx];
        end else begin
            qt_rd_data <= '0;
        end
    end

endmodule

// ==== jpeg_hdr.f ====
common/jpeg_hdr_pkg.sv
source/marker_fsm.sv
source/seg_counter.sv
source/sof_capture.sv
dqt/dqt_loader.sv
source/jpeg_hdr_top.sv
verif/tb_clk_gen.sv
verif/jpeg_hdr_sva.sv
verif/jpeg_hdr_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the JPEG header parser testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 \
    -f jpeg_hdr.f --top-module jpeg_hdr_tb -o jpeg_hdr_sim \
    && ./obj_dir/jpeg_hdr_sim > sim.log 2>&1 \
    || echo "build or simulation exited with an error"
cat sim.log 2>/dev/null
grep -qx "all tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== source/jpeg_hdr_top.sv ====
// JPEG header parser top; one byte per data_valid strobe, no back-pressure
// Segment lengths below 2 are not handled

`timescale 1ns/10ps

module jpeg_hdr_top import jpeg_hdr_pkg::*; #(
    parameter int QT_COUNT = 4            // Tables stored, 2 or 4
) (
    input  logic       clk,
    input  logic       rst_n,
    input  byte_t      data_in,
    input  logic       data_valid,
    input  qt_id_t     qt_rd_id,          // Table read port
    input  coeff_idx_t qt_rd_idx,
    output word_t      img_height,
    output word_t      img_width,
    output logic       qtable_loaded,
    output qt_id_t     qtable_id,
    output word_t      qt_rd_data,
    output logic       start_scan,
    output byte_t      scan_data,
    output logic       scan_valid
);

    // Enables from the marker FSM
    logic  len_hi_en;
    logic  len_lo_en;
    logic  seg_en;
    logic  sof_en;
    logic  dqt_en;
    logic  dqt_start;

    // Segment position
    word_t payload_idx;
    logic  seg_last;

    marker_fsm u_marker_fsm (
        .clk        (clk),
        .rst_n      (rst_n),
        .data_in    (data_in),
        .data_valid (data_valid),
        .seg_last   (seg_last),
        .len_hi_en  (len_hi_en),
        .len_lo_en  (len_lo_en),
        .seg_en     (seg_en),
        .sof_en     (sof_en),
        .dqt_en     (dqt_en),
        .dqt_start  (dqt_start),
        .start_scan (start_scan),
        .scan_data  (scan_data),
        .scan_valid (scan_valid)
    );

    seg_counter u_seg_counter (
        .clk         (clk),
        .rst_n       (rst_n),
        .data_in     (data_in),
        .data_valid  (data_valid),
        .len_hi_en   (len_hi_en),
        .len_lo_en   (len_lo_en),
        .seg_en      (seg_en),
        .payload_idx (payload_idx),
        .seg_last    (seg_last)
    );

    sof_capture u_sof_capture (
        .clk         (clk),
        .rst_n       (rst_n),
        .data_in     (data_in),
        .data_valid  (data_valid),
        .sof_en      (sof_en),
        .payload_idx (payload_idx),
        .img_height  (img_height),
        .img_width   (img_width)
    );

    dqt_loader #(
        .QT_COUNT (QT_COUNT)
    ) u_dqt_loader (
        .clk           (clk),
        .rst_n         (rst_n),
        .data_in       (data_in),
        .data_valid    (data_valid),
        .dqt_en        (dqt_en),
        .dqt_start     (dqt_start),
        .qt_rd_id      (qt_rd_id),
        .qt_rd_idx     (qt_rd_idx),
        .qtable_loaded (qtable_loaded),
        .qtable_id     (qtable_id),
        .qt_rd_data    (qt_rd_data)
    );

endmodule

// ==== source/marker_fsm.sv ====
// Marker search and segment dispatch; after the SOS header every byte is
// forwarded to scan_data until reset, 0xFF included

`timescale 1ns/10ps

module marker_fsm import jpeg_hdr_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  byte_t data_in,
    input  logic  data_valid,
    input  logic  seg_last,    // Current payload byte ends the segment
    output logic  len_hi_en,
    output logic  len_lo_en,
    output logic  seg_en,
    output logic  sof_en,
    output logic  dqt_en,
    output logic  dqt_start,   // Info byte of a DQT follows
    output logic  start_scan,
    output byte_t scan_data,
    output logic  scan_valid
);

    parser_state_t state;
    parser_state_t next_state;
    byte_t         cur_marker;   // Code of the segment being parsed
    logic          seg_done;

    assign seg_done = data_valid && seg_last;

    // ==================================================
    // Next state
    // ==================================================
    always_comb begin
        next_state = state;
        case (state)
            find_ff: if (data_valid && data_in == MARK_PREFIX) next_state = got_ff;
            got_ff: begin
                if (data_valid) begin
                    if (data_in == MARK_PREFIX) begin
                        next_state = got_ff;          // Fill byte
                    end else if (data_in == 8'h00 || data_in == MARK_SOI) begin
                        next_state = find_ff;         // Stuffing or standalone SOI
                    end else begin
                        next_state = len_hi;
                    end
                end
            end
            len_hi: if (data_valid) next_state = len_lo;
            len_lo: begin
                if (data_valid) begin
                    // Dispatch on the stored code
                    if (cur_marker == MARK_SOF0)     next_state = sof;
                    else if (cur_marker == MARK_DQT) next_state = dqt;
                    else                             next_state = skip;
                end
            end
            sof, dqt, skip: begin
                if (seg_done) next_state = (cur_marker == MARK_SOS) ? pass : find_ff;
            end
            pass:    next_state = pass;              // Held until reset
            default: next_state = find_ff;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= find_ff;
            cur_marker <= '0;
        end else begin
            state <= next_state;
            if (state == got_ff && next_state == len_hi) cur_marker <= data_in;
        end
    end

    // Enables follow the state, receivers qualify with data_valid
    assign len_hi_en = (state == len_hi);
    assign len_lo_en = (state == len_lo);
    assign sof_en    = (state == sof);
    assign dqt_en    = (state == dqt);
    assign seg_en    = (state == sof) || (state == dqt) || (state == skip);
    assign dqt_start = (state == len_lo) && (cur_marker == MARK_DQT);

    // ==================================================
    // Scan output stage
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_scan <= 1'b0;
            scan_valid <= 1'b0;
        end else begin
            start_scan <= (state != pass) && (next_state == pass); // Last SOS header byte
            scan_valid <= (state == pass) && data_valid;
        end
    end

    // Data word only, qualified by scan_valid
    always_ff @(posedge clk) begin
        if (state == pass && data_valid) scan_data <= data_in;
    end

endmodule

// ==== source/seg_counter.sv ====
// Segment length capture and payload position
// A length of 2 (empty payload) never raises seg_last

`timescale 1ns/10ps

module seg_counter import jpeg_hdr_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  byte_t data_in,
    input  logic  data_valid,
    input  logic  len_hi_en,
    input  logic  len_lo_en,
    input  logic  seg_en,
    output word_t payload_idx,  // Index of the current payload byte
    output logic  seg_last      // Current payload byte is the final one
);

    byte_t len_hi_q;   // High length byte, waits for the low one
    word_t remain;     // Payload bytes still to come, current one included

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            len_hi_q    <= '0;
            remain      <= '0;
            payload_idx <= '0;
        end else if (data_valid) begin
            if (len_hi_en) begin
                len_hi_q <= data_in;
            end else if (len_lo_en) begin
                // Length field counts its own two bytes
                remain      <= {len_hi_q, data_in} - 16'd2;
                payload_idx <= '0;
            end else if (seg_en) begin
                remain      <= remain - 16'd1;
                payload_idx <= payload_idx + 16'd1;
            end
        end
    end

    assign seg_last = (remain == 16'd1);

endmodule

// ==== source/sof_capture.sv ====
// SOF0 frame size capture; precision and component data are ignored
// Values hold until the next SOF0 or reset

`timescale 1ns/10ps

module sof_capture import jpeg_hdr_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  byte_t data_in,
    input  logic  data_valid,
    input  logic  sof_en,
    input  word_t payload_idx,
    output word_t img_height,
    output word_t img_width
);

    byte_t hi_byte;   // Upper half until the low byte arrives

    // Upper bytes are held so each dimension changes in one step
    always_ff @(posedge clk) begin
        if (sof_en && data_valid && (payload_idx == 16'd1 || payload_idx == 16'd3)) begin
            hi_byte <= data_in;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            img_height <= '0;
            img_width  <= '0;
        end else if (sof_en && data_valid) begin
            if (payload_idx == 16'd2) img_height <= {hi_byte, data_in}; // Big-endian
            if (payload_idx == 16'd4) img_width  <= {hi_byte, data_in};
        end
    end

endmodule

// ==== verif/jpeg_hdr_sva.sv ====
// Protocol checks bound to the parser top; all are disabled while in reset

`timescale 1ns/10ps

module jpeg_hdr_sva import jpeg_hdr_pkg::*; (
    input logic          clk,
    input logic          rst_n,
    input logic          qtable_loaded,
    input logic          start_scan,
    input logic          scan_valid,
    input parser_state_t state
);

    logic scan_seen;        // start_scan has fired since reset
    int   fail_count = 0;   // Failures seen, folded into the testbench verdict

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scan_seen <= 1'b0;
        end else if (start_scan) begin
            scan_seen <= 1'b1;
        end
    end

    // ==================================================
    // Pulse and scan rules
    // ==================================================
    loaded_single: assert property (@(posedge clk) disable iff (!rst_n)
        qtable_loaded |=> !qtable_loaded)
        else begin
            fail_count++;
            $error("qtable_loaded held for two cycles");
        end

    start_once: assert property (@(posedge clk) disable iff (!rst_n)
        start_scan |-> !scan_seen)
        else begin
            fail_count++;
            $error("start_scan fired a second time");
        end

    scan_after_start: assert property (@(posedge clk) disable iff (!rst_n)
        scan_valid |-> scan_seen)
        else begin
            fail_count++;
            $error("scan_valid before start_scan");
        end

    pass_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        state == pass |=> state == pass)
        else begin
            fail_count++;
            $error("parser left the pass state");
        end

endmodule

bind jpeg_hdr_top jpeg_hdr_sva u_jpeg_hdr_sva (
    .clk           (clk),
    .rst_n         (rst_n),
    .qtable_loaded (qtable_loaded),
    .start_scan    (start_scan),
    .scan_valid    (scan_valid),
    .state         (u_marker_fsm.state)
);

// ==== verif/jpeg_hdr_tb.sv ====
// Directed tests for the JPEG header parser; tests run in order on one stream
// The stuffing test expects the frame size left by the SOF0 test

`timescale 1ns/10ps

module jpeg_hdr_tb import jpeg_hdr_pkg::*; ();

    localparam word_t IMG_H     = 16'd480;
    localparam word_t IMG_W     = 16'd640;
    localparam int    SCAN_LEN  = 40;     // Bytes sent after the SOS header
    localparam int    EV_LOADED = 0;
    localparam int    EV_START  = 1;
    localparam int    EV_SCAN   = 2;

    logic       clk;
    logic       rst_n;
    byte_t      data_in;
    logic       data_valid;
    qt_id_t     qt_rd_id;
    coeff_idx_t qt_rd_idx;
    word_t      img_height;
    word_t      img_width;
    logic       qtable_loaded;
    qt_id_t     qtable_id;
    word_t      qt_rd_data;
    logic       start_scan;
    byte_t      scan_data;
    logic       scan_valid;

    // Observed events and expected tables
    qt_id_t      loaded_q [$];
    byte_t       scan_q   [$];
    byte_t       sent_q   [$];
    int          start_count = 0;
    word_t       exp_qt [4][64];
    int          error_count = 0;
    int          check_count = 0;
    logic [31:0] lcg_state   = 32'hb39f_921e;

    tb_clk_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    jpeg_hdr_top u_jpeg_hdr_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .data_in       (data_in),
        .data_valid    (data_valid),
        .qt_rd_id      (qt_rd_id),
        .qt_rd_idx     (qt_rd_idx),
        .img_height    (img_height),
        .img_width     (img_width),
        .qtable_loaded (qtable_loaded),
        .qtable_id     (qtable_id),
        .qt_rd_data    (qt_rd_data),
        .start_scan    (start_scan),
        .scan_data     (scan_data),
        .scan_valid    (scan_valid)
    );

    // Outputs are registered, so mid-cycle sampling is stable
    always @(negedge clk) begin
        if (qtable_loaded) loaded_q.push_back(qtable_id);
        if (start_scan)    start_count++;
        if (scan_valid)    scan_q.push_back(scan_data);
    end

    // ==================================================
    // Stimulus helpers
    // ==================================================
    function automatic byte_t rand_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];           // Upper bits, better period
    endfunction

    // Called at posedge + 1 ns, returns at the next posedge + 1 ns
    task automatic send_byte(input byte_t b);
        data_in    = b;
        data_valid = 1'b1;
        @(posedge clk);
        #1;
        data_valid = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic marker_head(input byte_t code, input word_t len);
        send_byte(MARK_PREFIX);
        send_byte(code);
        send_byte(len[15:8]);              // Length is big-endian
        send_byte(len[7:0]);
    endtask

    function automatic int event_count(input int kind);
        case (kind)
            EV_LOADED: return loaded_q.size();
            EV_START:  return start_count;
            default:   return scan_q.size();
        endcase
    endfunction

    task automatic wait_events(input int kind, input int n, input string what);
        int cycles;
        cycles = 0;
        while (event_count(kind) < n && cycles < 400) begin
            @(negedge clk);
            cycles++;
        end
        if (event_count(kind) < n) begin
            $display("timeout at %0t after %0d cycles waiting for %s", $time, cycles, what);
            error_count++;
        end
        @(posedge clk);
        #1;                                // Back to the drive point
    endtask

    // ==================================================
    // Compare tasks
    // ==================================================
    task automatic compare_word(input string name, input word_t got, input word_t exp);
        check_count++;
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic compare_id(input string name, input qt_id_t got, input qt_id_t exp);
        check_count++;
        if (got !== exp) begin
            $display("error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic compare_byte(input string name, input byte_t got, input byte_t exp);
        check_count++;
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic compare_count(input string name, input int got, input int exp);
        check_count++;
        if (got != exp) begin
            $display("error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            error_count++;
        end
    endtask

    // Read port has one cycle of latency
    task automatic read_table(input qt_id_t id);
        for (int i = 0; i < 64; i++) begin
            qt_rd_id  = id;
            qt_rd_idx = coeff_idx_t'(i);
            @(posedge clk);
            #1;
            compare_word($sformatf("qt_rd_data[%0d][%0d]", id, i), qt_rd_data, exp_qt[id][i]);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("%s: %s, %0d errors", name,
                 (error_count == errs_before) ? "ok" : "mismatch", error_count - errs_before);
    endtask

    // ==================================================
    // Directed tests
    // ==================================================
    task automatic reset_values();
        int errs;
        errs = error_count;
        compare_word("img_height", img_height, 16'd0);
        compare_word("img_width", img_width, 16'd0);
        for (int i = 0; i < 64; i++) begin
            exp_qt[3][i] = '0;                   // Table 3 is never loaded
        end
        read_table(2'd3);
        report_test("reset_values", errs);
    endtask

    task automatic sof_after_app0();
        int errs;
        int n;
        errs = error_count;
        send_byte(MARK_PREFIX);
        send_byte(MARK_SOI);                     // Standalone, no length
        n = 3 + int'(rand_byte()) % 16;          // APP0 payload size
        marker_head(8'hE0, word_t'(n + 2));
        repeat (n) send_byte(rand_byte());
        marker_head(MARK_SOF0, 16'd17);          // Three components
        send_byte(8'h08);                        // Sample precision
        send_byte(IMG_H[15:8]);
        send_byte(IMG_H[7:0]);
        send_byte(IMG_W[15:8]);
        send_byte(IMG_W[7:0]);
        send_byte(8'h03);
        for (int c = 1; c <= 3; c++) begin
            send_byte(byte_t'(c));
            send_byte(8'h11);                    // Sampling factors
            send_byte(8'h00);
        end
        idle_cycles(2);
        compare_word("img_height", img_height, IMG_H);
        compare_word("img_width", img_width, IMG_W);
        compare_count("qtable_loaded pulses", loaded_q.size(), 0);
        compare_count("start_scan pulses", start_count, 0);
        report_test("sof_after_app0", errs);
    endtask

    task automatic dqt_single_8bit();
        int    errs;
        int    base;
        byte_t b;
        errs = error_count;
        base = loaded_q.size();
        marker_head(MARK_DQT, 16'd67);           // Info + 64 bytes
        send_byte(8'h01);                        // 8-bit, id 1
        for (int i = 0; i < 64; i++) begin
            b = rand_byte();
            exp_qt[1][i] = {8'h00, b};
            send_byte(b);
        end
        wait_events(EV_LOADED, base + 1, "qtable_loaded of table 1");
        if (loaded_q.size() > base) compare_id("qtable_id", loaded_q[base], 2'd1);
        compare_count("qtable_loaded pulses", loaded_q.size() - base, 1);
        read_table(2'd1);
        report_test("dqt_single_8bit", errs);
    endtask

    task automatic dqt_two_tables();
        int    errs;
        int    base;
        byte_t hi;
        byte_t lo;
        errs = error_count;
        base = loaded_q.size();
        marker_head(MARK_DQT, 16'd196);          // 129 + 65 payload bytes
        send_byte(8'h12);                        // 16-bit, id 2
        for (int i = 0; i < 64; i++) begin
            hi = rand_byte();
            lo = rand_byte();
            exp_qt[2][i] = {hi, lo};
            send_byte(hi);
            send_byte(lo);
        end
        send_byte(8'h00);                        // 8-bit, id 0
        for (int i = 0; i < 64; i++) begin
            lo = rand_byte();
            exp_qt[0][i] = {8'h00, lo};
            send_byte(lo);
        end
        wait_events(EV_LOADED, base + 2, "qtable_loaded of tables 2 and 0");
        if (loaded_q.size() >= base + 2) begin
            compare_id("qtable_id of first table", loaded_q[base], 2'd2);
            compare_id("qtable_id of second table", loaded_q[base + 1], 2'd0);
        end
        compare_count("qtable_loaded pulses", loaded_q.size() - base, 2);
        read_table(2'd2);
        read_table(2'd0);
        report_test("dqt_two_tables", errs);
    endtask

    task automatic stuffing_and_dht();
        int errs;
        int base;
        errs = error_count;
        base = loaded_q.size();
        send_byte(MARK_PREFIX);
        send_byte(8'h00);                        // Stuffed pair
        send_byte(MARK_PREFIX);
        send_byte(MARK_PREFIX);                  // Fill bytes ahead of the code
        marker_head(8'hC4, 16'd8);               // DHT, skipped
        send_byte(8'h10);
        send_byte(MARK_PREFIX);                  // Looks like SOF0 inside the payload
        send_byte(MARK_SOF0);
        send_byte(8'h00);
        send_byte(8'h05);
        send_byte(8'h07);
        send_byte(MARK_PREFIX);
        send_byte(8'h00);
        idle_cycles(2);
        compare_word("img_height", img_height, IMG_H);
        compare_word("img_width", img_width, IMG_W);
        compare_count("qtable_loaded pulses", loaded_q.size() - base, 0);
        compare_count("start_scan pulses", start_count, 0);
        report_test("stuffing_and_dht", errs);
    endtask

    task automatic scan_pass_through();
        int    errs;
        int    base;
        byte_t b;
        errs = error_count;
        base = start_count;
        scan_q.delete();
        sent_q.delete();
        marker_head(MARK_SOS, 16'd12);
        send_byte(8'h03);
        for (int c = 1; c <= 3; c++) begin
            send_byte(byte_t'(c));
            send_byte(8'h00);                    // Table selectors
        end
        send_byte(8'h00);                        // Spectral start
        send_byte(8'h3F);                        // Spectral end
        send_byte(8'h00);
        wait_events(EV_START, base + 1, "start_scan");
        for (int i = 0; i < SCAN_LEN; i++) begin
            b = rand_byte();
            if (i % 7 == 2) b = MARK_PREFIX;     // FF D9 pairs must pass unchanged
            else if (i % 7 == 3) b = 8'hD9;
            sent_q.push_back(b);
            idle_cycles(int'(rand_byte()) % 4);  // Gap in data_valid
            send_byte(b);
        end
        wait_events(EV_SCAN, SCAN_LEN, "scan bytes");
        idle_cycles(4);
        compare_count("start_scan pulses", start_count - base, 1);
        compare_count("scan byte count", scan_q.size(), SCAN_LEN);
        for (int i = 0; i < SCAN_LEN && i < scan_q.size(); i++) begin
            compare_byte($sformatf("scan_data[%0d]", i), scan_q[i], sent_q[i]);
        end
        report_test("scan_pass_through", errs);
    endtask

    // ==================================================
    // Sequence
    // ==================================================
    initial begin
        int cycles;
        data_in    = '0;
        data_valid = 1'b0;
        qt_rd_id   = '0;
        qt_rd_idx  = '0;
        cycles     = 0;
        while (!rst_n && cycles < 40) begin
            @(posedge clk);
            cycles++;
        end
        if (!rst_n) begin
            $display("reset was never released");
            error_count++;
        end
        @(posedge clk);
        #1;
        reset_values();
        sof_after_app0();
        dqt_single_8bit();
        dqt_two_tables();
        stuffing_and_dht();
        scan_pass_through();
        // Assertion failures of the bound checker
        error_count += u_jpeg_hdr_top.u_jpeg_hdr_sva.fail_count;
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== verif/tb_clk_gen.sv ====
// Testbench clock with a 4 ns period; active-low reset held for 10 cycles

`timescale 1ns/10ps

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    initial clk = 1'b0;
    always #2 clk = ~clk;    // 4 ns period

    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        #1;                  // Release away from the edge
        rst_n = 1'b1;
    end

endmodule
